// File: src/irq_tsc_pkg.sv
`default_nettype none

package irq_tsc_pkg;

   localparam int DW = 32;                  // MSR data width

   typedef logic [DW-1:0] msr_data_t;

   // MSR map of the interrupt and timer block
   typedef enum logic [2:0] {
      MSR_PSR = 3'd0,
      MSR_IMR = 3'd1,
      MSR_IRR = 3'd2,
      MSR_TSR = 3'd3,
      MSR_TCR = 3'd4
   } msr_addr_e;

   localparam int TCR_CNT_W   = 28;         // Compare count in TCR[27:0]
   localparam int TCR_EN_BIT  = 28;         // Counter enable
   localparam int TCR_I_BIT   = 29;         // Interrupt enable
   localparam int TCR_P_BIT   = 30;         // Interrupt pending
   localparam int PSR_IRE_BIT = 0;          // Global interrupt enable

   typedef logic [TCR_CNT_W-1:0] tcr_cnt_t;

   typedef struct packed {
      logic      vld;
      msr_addr_e addr;
      msr_data_t data;
   } msr_wr_t;

   typedef struct packed {
      logic      vld;
      msr_addr_e addr;
   } msr_rd_t;

   typedef struct packed {
      logic      vld;
      msr_data_t data;
   } msr_rsp_t;

endpackage

`default_nettype wire

// File: src/irq_line_sync.sv
`timescale 1ns/1ps
`default_nettype none

module irq_line_sync #(
   parameter int NIRQ        = 32,
   parameter int SYNC_STAGES = 2
) (
   input  wire             clk,
   input  wire             rst_n,
   input  wire [NIRQ-1:0]  irqs,
   output logic [NIRQ-1:0] irqs_sync
);

   logic [SYNC_STAGES-1:0][NIRQ-1:0] sync_q;   // Stage 0 samples the pins

   if (SYNC_STAGES < 2) begin : g_bad_depth
      $error("irq_line_sync needs at least two stages");
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= irqs;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign irqs_sync = sync_q[SYNC_STAGES-1];   // Last stage is metastability free

endmodule

`default_nettype wire

// File: src/tsc_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_timer (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        tsr_we,
   input  wire                        tcr_we,
   input  wire irq_tsc_pkg::msr_data_t wr_data,
   output irq_tsc_pkg::msr_data_t     tsr,
   output irq_tsc_pkg::msr_data_t     tcr,
   output logic                       tsc_irq
);

   import irq_tsc_pkg::*;

   tcr_cnt_t  cnt_field;
   logic      count_en;
   logic      irq_en;
   logic      match;
   msr_data_t tsr_nxt;
   msr_data_t tcr_nxt;

   assign cnt_field = tcr[TCR_CNT_W-1:0];
   assign count_en  = tcr[TCR_EN_BIT];
   assign irq_en    = tcr[TCR_I_BIT];

   // Only the low count bits of TSR take part in the compare
   assign match = irq_en && (tsr[TCR_CNT_W-1:0] == cnt_field);

   always_comb begin
      tsr_nxt = tsr;
      if (tsr_we) begin
         tsr_nxt = wr_data;                   // Software load wins over counting
      end else if (count_en) begin
         tsr_nxt = tsr + 32'd1;
      end

      tcr_nxt = tcr_we ? wr_data : tcr;       // P is loaded too
      if (match) begin
         tcr_nxt[TCR_P_BIT] = 1'b1;           // Compare beats the write
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tsr <= '0;
         tcr <= '0;
      end else begin
         tsr <= tsr_nxt;
         tcr <= tcr_nxt;
      end
   end

   assign tsc_irq = tcr[TCR_P_BIT];

   // P can only come up through a compare hit, and that needs I
   a_no_pend_without_ie : assert property (
      @(posedge clk) disable iff (!rst_n)
      (!tcr[TCR_P_BIT] && !tcr[TCR_I_BIT] && !tcr_we) |=> !tcr[TCR_P_BIT]
   ) else $error("TCR.P rose while TCR.I was clear");

endmodule

`default_nettype wire

// File: src/irqc.sv
`timescale 1ns/1ps
`default_nettype none

module irqc #(
   parameter int NIRQ           = 32,
   parameter int IRQ_LINENO_TSC = 0
) (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire [NIRQ-1:0]             irqs_sync,
   input  wire                        tsc_irq,
   input  wire                        ire,
   input  wire                        imr_we,
   input  wire irq_tsc_pkg::msr_data_t wr_data,
   output irq_tsc_pkg::msr_data_t     imr,
   output irq_tsc_pkg::msr_data_t     irr,
   output logic                       irq_req
);

   import irq_tsc_pkg::*;

   logic [NIRQ-1:0] lines;                   // External lines plus TSC
   logic [NIRQ-1:0] pend;

   if (NIRQ > DW || IRQ_LINENO_TSC >= NIRQ) begin : g_bad_cfg
      $error("irqc line configuration out of range");
   end

   always_comb begin
      lines = irqs_sync;
      lines[IRQ_LINENO_TSC] = irqs_sync[IRQ_LINENO_TSC] | tsc_irq;
   end

   assign pend = lines & ~imr[NIRQ-1:0];
   assign irr  = msr_data_t'(pend);          // Upper lines read as zero

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         imr     <= '1;                      // Everything masked out of reset
         irq_req <= 1'b0;
      end else begin
         if (imr_we) begin
            imr <= wr_data;
         end
         irq_req <= ire & (|irr);
      end
   end

   // Gate from PSR.IRE must hold a full cycle ahead of the request
   a_req_needs_ire : assert property (
      @(posedge clk) disable iff (!rst_n)
      !ire |=> !irq_req
   ) else $error("irq_req high one cycle after ire was low");

endmodule

`default_nettype wire

// File: src/msr_port.sv
`timescale 1ns/1ps
`default_nettype none

module msr_port (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire irq_tsc_pkg::msr_wr_t   msr_wr,
   input  wire irq_tsc_pkg::msr_rd_t   msr_rd,
   output irq_tsc_pkg::msr_rsp_t       msr_rsp,
   input  wire irq_tsc_pkg::msr_data_t tsr,
   input  wire irq_tsc_pkg::msr_data_t tcr,
   input  wire irq_tsc_pkg::msr_data_t imr,
   input  wire irq_tsc_pkg::msr_data_t irr,
   output logic                        tsr_we,
   output logic                        tcr_we,
   output logic                        imr_we,
   output irq_tsc_pkg::msr_data_t      wr_data,
   output logic                        ire
);

   import irq_tsc_pkg::*;

   logic      psr_we;
   msr_data_t psr_val;
   msr_data_t rd_data;

   // One write strobe per register owner
   assign psr_we  = msr_wr.vld && (msr_wr.addr == MSR_PSR);
   assign imr_we  = msr_wr.vld && (msr_wr.addr == MSR_IMR);
   assign tsr_we  = msr_wr.vld && (msr_wr.addr == MSR_TSR);
   assign tcr_we  = msr_wr.vld && (msr_wr.addr == MSR_TCR);
   assign wr_data = msr_wr.data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ire <= 1'b0;
      end else if (psr_we) begin
         ire <= msr_wr.data[PSR_IRE_BIT];    // Other PSR bits not implemented
      end
   end

   always_comb begin
      psr_val = '0;
      psr_val[PSR_IRE_BIT] = ire;
   end

   // Read mux sees the pre-write values of the request cycle
   always_comb begin
      case (msr_rd.addr)
         MSR_PSR: rd_data = psr_val;
         MSR_IMR: rd_data = imr;
         MSR_IRR: rd_data = irr;
         MSR_TSR: rd_data = tsr;
         MSR_TCR: rd_data = tcr;
         default: rd_data = '0;              // Unmapped codes
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         msr_rsp <= '0;
      end else begin
         msr_rsp.vld <= msr_rd.vld;
         if (msr_rd.vld) begin
            msr_rsp.data <= rd_data;
         end
      end
   end

   a_one_wr_strobe : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0({psr_we, imr_we, tsr_we, tcr_we})
   ) else $error("More than one MSR write strobe active");

endmodule

`default_nettype wire

// File: src/irq_tsc_top.sv
`timescale 1ns/1ps
`default_nettype none

module irq_tsc_top #(
   parameter int NIRQ           = 32,
   parameter int IRQ_LINENO_TSC = 0,       // Line shared with the TSC interrupt
   parameter int SYNC_STAGES    = 2
) (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire [NIRQ-1:0]            irqs,
   input  wire irq_tsc_pkg::msr_wr_t msr_wr,
   input  wire irq_tsc_pkg::msr_rd_t msr_rd,
   output irq_tsc_pkg::msr_rsp_t     msr_rsp,
   output logic                      irq_req
);

   import irq_tsc_pkg::*;

   logic [NIRQ-1:0] irqs_sync;
   logic            tsc_irq;
   logic            ire;
   logic            tsr_we;
   logic            tcr_we;
   logic            imr_we;
   msr_data_t       wr_data;
   msr_data_t       tsr;
   msr_data_t       tcr;
   msr_data_t       imr;
   msr_data_t       irr;

   irq_line_sync #(
      .NIRQ        (NIRQ),
      .SYNC_STAGES (SYNC_STAGES)
   ) u_line_sync (
      .clk       (clk),
      .rst_n     (rst_n),
      .irqs      (irqs),
      .irqs_sync (irqs_sync)
   );

   tsc_timer u_tsc (
      .clk     (clk),
      .rst_n   (rst_n),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .wr_data (wr_data),
      .tsr     (tsr),
      .tcr     (tcr),
      .tsc_irq (tsc_irq)
   );

   irqc #(
      .NIRQ           (NIRQ),
      .IRQ_LINENO_TSC (IRQ_LINENO_TSC)
   ) u_irqc (
      .clk       (clk),
      .rst_n     (rst_n),
      .irqs_sync (irqs_sync),
      .tsc_irq   (tsc_irq),
      .ire       (ire),
      .imr_we    (imr_we),
      .wr_data   (wr_data),
      .imr       (imr),
      .irr       (irr),
      .irq_req   (irq_req)
   );

   msr_port u_msr (
      .clk     (clk),
      .rst_n   (rst_n),
      .msr_wr  (msr_wr),
      .msr_rd  (msr_rd),
      .msr_rsp (msr_rsp),
      .tsr     (tsr),
      .tcr     (tcr),
      .imr     (imr),
      .irr     (irr),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .imr_we  (imr_we),
      .wr_data (wr_data),
      .ire     (ire)
   );

endmodule

`default_nettype wire

// File: bench/tb_irq_tsc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_irq_tsc;

   import irq_tsc_pkg::*;

   localparam int NIRQ        = 32;
   localparam int TSC_LINE    = 0;
   localparam int SYNC_STAGES = 2;
   localparam int RSP_TIMEOUT = 4;
   localparam msr_data_t TCR_RUN = 32'h3000_0018;   // EN and I set, count 24

   logic            clk = 1'b0;
   logic            rst_n;
   logic [NIRQ-1:0] irqs;
   msr_wr_t         msr_wr;
   msr_rd_t         msr_rd;
   msr_rsp_t        msr_rsp;
   logic            irq_req;

   integer seed      = 32'h3790;
   int     errors    = 0;
   int     timeouts  = 0;
   string  test_name = "none";

   logic [SYNC_STAGES-1:0][NIRQ-1:0] m_sync;        // Model of the line synchronizer
   logic [NIRQ-1:0] m_lines;
   msr_data_t       m_imr;
   msr_data_t       m_irr;
   msr_data_t       m_tsr;
   msr_data_t       m_tcr;
   msr_data_t       m_tcr_nxt;
   msr_data_t       m_rsp;
   logic            m_ire;
   logic            m_req;
   logic            m_rsp_vld;

   always #5 clk = ~clk;

   irq_tsc_top #(
      .NIRQ           (NIRQ),
      .IRQ_LINENO_TSC (TSC_LINE),
      .SYNC_STAGES    (SYNC_STAGES)
   ) u_irq_tsc_top (
      .clk     (clk),
      .rst_n   (rst_n),
      .irqs    (irqs),
      .msr_wr  (msr_wr),
      .msr_rd  (msr_rd),
      .msr_rsp (msr_rsp),
      .irq_req (irq_req)
   );

   function automatic msr_data_t expected_read(input msr_addr_e reg_addr);
      msr_data_t val;
      val = '0;
      case (reg_addr)
         MSR_PSR: val[PSR_IRE_BIT] = m_ire;
         MSR_IMR: val = m_imr;
         MSR_IRR: val = m_irr;
         MSR_TSR: val = m_tsr;
         MSR_TCR: val = m_tcr;
         default: val = '0;
      endcase
      return val;
   endfunction

   function automatic void report_mismatch(input string what, input msr_data_t exp_val,
                                           input msr_data_t act_val);
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
   endfunction

   always_comb begin
      m_lines = m_sync[SYNC_STAGES-1];
      m_lines[TSC_LINE] = m_lines[TSC_LINE] | m_tcr[TCR_P_BIT];   // TSC shares its line
      m_irr = '0;
      m_irr[NIRQ-1:0] = m_lines & ~m_imr[NIRQ-1:0];
   end

   always_comb begin
      m_tcr_nxt = m_tcr;
      if (msr_wr.vld && msr_wr.addr == MSR_TCR) begin
         m_tcr_nxt = msr_wr.data;
      end
      if (m_tcr[TCR_I_BIT] && m_tsr[TCR_CNT_W-1:0] == m_tcr[TCR_CNT_W-1:0]) begin
         m_tcr_nxt[TCR_P_BIT] = 1'b1;                 // Compare hit wins
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_sync    <= '0;
         m_imr     <= '1;
         m_ire     <= 1'b0;
         m_tsr     <= '0;
         m_tcr     <= '0;
         m_req     <= 1'b0;
         m_rsp     <= '0;
         m_rsp_vld <= 1'b0;
      end else begin
         m_sync <= {m_sync[SYNC_STAGES-2:0], irqs};
         if (msr_wr.vld && msr_wr.addr == MSR_IMR) begin
            m_imr <= msr_wr.data;
         end
         if (msr_wr.vld && msr_wr.addr == MSR_PSR) begin
            m_ire <= msr_wr.data[PSR_IRE_BIT];
         end
         if (msr_wr.vld && msr_wr.addr == MSR_TSR) begin
            m_tsr <= msr_wr.data;
         end else if (m_tcr[TCR_EN_BIT]) begin
            m_tsr <= m_tsr + 32'd1;
         end
         m_tcr     <= m_tcr_nxt;
         m_req     <= m_ire & (|m_irr);
         m_rsp_vld <= msr_rd.vld;
         if (msr_rd.vld) begin
            m_rsp <= expected_read(msr_rd.addr);      // Value of the request cycle
         end
      end
   end

   a_irq_req : assert property (@(posedge clk) disable iff (!rst_n) irq_req == m_req)
      else report_mismatch("irq_req", 32'($sampled(m_req)), 32'($sampled(irq_req)));

   a_rsp_vld : assert property (@(posedge clk) disable iff (!rst_n) msr_rsp.vld == m_rsp_vld)
      else report_mismatch("rsp_vld", 32'($sampled(m_rsp_vld)), 32'($sampled(msr_rsp.vld)));

   a_rsp_data : assert property (@(posedge clk) disable iff (!rst_n)
                                 msr_rsp.vld |-> msr_rsp.data == m_rsp)
      else report_mismatch("rsp_data", $sampled(m_rsp), $sampled(msr_rsp.data));

   a_rsp_next : assert property (@(posedge clk) disable iff (!rst_n) msr_rd.vld |=> msr_rsp.vld)
      else begin
         errors++;
         $display("Error in %s: no read response in the cycle after the strobe", test_name);
      end

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic write_reg(input msr_addr_e reg_addr, input msr_data_t value);
      @(posedge clk);
      msr_wr <= '{vld: 1'b1, addr: reg_addr, data: value};
      @(posedge clk);
      msr_wr <= '0;
   endtask

   task automatic read_reg(input msr_addr_e reg_addr);
      int waited;
      @(posedge clk);
      msr_rd <= '{vld: 1'b1, addr: reg_addr};
      @(posedge clk);
      msr_rd <= '0;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (msr_rsp.vld !== 1'b1 && waited < RSP_TIMEOUT);
      if (msr_rsp.vld !== 1'b1) begin
         timeouts++;
         $display("Timeout in %s: read of %s got no response", test_name, reg_addr.name());
      end
   endtask

   task automatic wait_for_req(input logic level, input int limit);
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (irq_req !== level && waited < limit);
      if (irq_req !== level) begin
         timeouts++;
         $display("Timeout in %s: irq_req did not go to %0b within %0d cycles",
                  test_name, level, limit);
      end
   endtask

   initial begin
      msr_data_t rnd;
      int        i;
      rst_n  = 1'b0;
      irqs   = '0;
      msr_wr = '0;
      msr_rd = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      test_name = "reset";
      read_reg(MSR_PSR);
      read_reg(MSR_IMR);
      read_reg(MSR_TSR);
      read_reg(MSR_TCR);
      read_reg(MSR_IRR);

      test_name = "round_trip";
      rnd = $random(seed);
      write_reg(MSR_IMR, rnd);
      read_reg(MSR_IMR);
      rnd = $random(seed);
      write_reg(MSR_IRR, rnd);                      // Read-only, must be ignored
      read_reg(MSR_IRR);
      read_reg(MSR_IMR);

      test_name = "irr_view";
      for (i = 0; i < 6; i++) begin
         rnd = $random(seed);
         write_reg(MSR_IMR, rnd);
         rnd = $random(seed);
         @(posedge clk);
         irqs <= rnd[NIRQ-1:0];
         idle_cycles(SYNC_STAGES + 1);
         read_reg(MSR_IRR);
      end

      test_name = "req_gating";
      write_reg(MSR_PSR, 32'h1);
      for (i = 0; i < 8; i++) begin
         rnd = $random(seed);
         write_reg(MSR_IMR, rnd);
         rnd = $random(seed);
         @(posedge clk);
         irqs <= rnd[NIRQ-1:0];
         idle_cycles(SYNC_STAGES + 2);
         if (i == 4) begin
            write_reg(MSR_PSR, 32'h0);
         end
      end
      write_reg(MSR_IMR, 32'h0);
      @(posedge clk);
      irqs <= 32'h0000_0010;
      write_reg(MSR_PSR, 32'h1);
      wait_for_req(1'b1, SYNC_STAGES + 6);
      write_reg(MSR_PSR, 32'h0);
      wait_for_req(1'b0, 4);
      write_reg(MSR_PSR, 32'h1);
      write_reg(MSR_IMR, 32'hFFFF_FFFF);
      wait_for_req(1'b0, 4);

      test_name = "tsc_irq";
      @(posedge clk);
      irqs <= '0;
      write_reg(MSR_IMR, ~(32'h1 << TSC_LINE));
      write_reg(MSR_TSR, 32'h0);
      write_reg(MSR_TCR, TCR_RUN);
      wait_for_req(1'b1, 64);
      read_reg(MSR_TCR);
      read_reg(MSR_TSR);
      write_reg(MSR_TCR, 32'h0);                    // Clears P, stops the counter
      wait_for_req(1'b0, 4);
      read_reg(MSR_TCR);

      test_name = "tsc_masked";
      write_reg(MSR_IMR, 32'hFFFF_FFFF);
      write_reg(MSR_TSR, 32'h0);
      write_reg(MSR_TCR, TCR_RUN);
      idle_cycles(40);
      read_reg(MSR_TCR);
      read_reg(MSR_IRR);
      write_reg(MSR_TCR, 32'h0);
      idle_cycles(4);

      $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: irq_tsc.f
src/irq_tsc_pkg.sv
src/irq_line_sync.sv
src/tsc_timer.sv
src/irqc.sv
src/msr_port.sv
src/irq_tsc_top.sv
bench/tb_irq_tsc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_irq_tsc
FILELIST  ?= irq_tsc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -xF '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(BUILD_DIR)
